// ==== soc_config.svh ====
// SoC bus segment configuration
// widths and sizes shared by the whole design

`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus address width, byte addressing
`define SOC_AW 16

// bus data width
`define SOC_DW 32

// byte enable width, one bit per data byte
`define SOC_BW 4

// memory byte-address width, 4 KiB
`define SOC_MEM_AW 12

// number of GPIO pins
`define SOC_GPIO_W 8

`endif

// ==== soc_pkg.sv ====
// SoC bus segment types
// meaningful widths and the decoder target encoding

`include "soc_config.svh"

package soc_pkg;

  //////////////////////////////
  // bus fields
  //////////////////////////////

  // byte address
  typedef logic [`SOC_AW-1:0] adr_t;

  // data word, read and write
  typedef logic [`SOC_DW-1:0] dat_t;

  // byte enables, lane b covers bits 8*b+7:8*b
  typedef logic [`SOC_BW-1:0] ben_t;

  // GPIO pin vector
  typedef logic [`SOC_GPIO_W-1:0] gpio_t;

  //////////////////////////////
  // decoder
  //////////////////////////////

  // target of an access
  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_GPIO,
    SEL_ERR
  } sel_t;

endpackage : soc_pkg

// ==== tcb_if.sv ====
// tightly coupled bus interface
// valid strobe request, response one cycle after the transfer

interface tcb_if (
  input logic clk
);

  //////////////////////////////
  // request
  //////////////////////////////

  // transfer strobe
  logic vld;
  // write enable, low for read
  logic wen;
  // byte address
  soc_pkg::adr_t adr;
  // byte enables, write only
  soc_pkg::ben_t ben;
  // write data
  soc_pkg::dat_t wdt;

  //////////////////////////////
  // response
  //////////////////////////////

  // read data, one cycle after transfer
  soc_pkg::dat_t rdt;
  // error, one cycle after transfer
  logic err;
  // ready, transfer when vld & rdy
  logic rdy;

  // request side
  modport man (
    input  clk,
    output vld, wen, adr, ben, wdt,
    input  rdt, err, rdy
  );

  // response side
  modport sub (
    input  clk,
    input  vld, wen, adr, ben, wdt,
    output rdt, err, rdy
  );

endinterface : tcb_if

// ==== soc_mem.sv ====
// single port tightly coupled memory
// byte enabled writes, registered whole word reads

`include "soc_config.svh"

module soc_mem (
  input logic bus,
  tcb_if.sub  tcb
);

  // words in the array
  localparam int unsigned WORDS = (2 ** `SOC_MEM_AW) / `SOC_BW;
  // lowest word address bit
  localparam int unsigned LSB = $clog2(`SOC_BW);

  //////////////////////////////
  // array
  //////////////////////////////

  soc_pkg::dat_t mem [0:WORDS-1];

  // word index of the current access
  logic [`SOC_MEM_AW-LSB-1:0] idx;

  // only the in-range bits, decoder already checked the rest
  assign idx = tcb.adr[`SOC_MEM_AW-1:LSB];

  //////////////////////////////
  // load/store
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (tcb.vld) begin
      if (tcb.wen) begin
        // write, only enabled lanes change
        for (int unsigned b = 0; b < `SOC_BW; b++) begin
          if (tcb.ben[b]) begin
            mem[idx][8*b+:8] <= tcb.wdt[8*b+:8];
          end
        end
      end else begin
        // read, whole word regardless of ben
        tcb.rdt <= mem[idx];
      end
    end
  end

  // never faults
  assign tcb.err = 1'b0;
  // never stalls
  assign tcb.rdy = 1'b1;

endmodule : soc_mem

// ==== tcb_dec.sv ====
// bus address decoder
// steers requests to memory or GPIO, muxes the responses, flags unmapped accesses

`include "soc_config.svh"

module tcb_dec (
  input logic bus,
  input logic rst,
  tcb_if.sub  man,
  tcb_if.man  mem,
  tcb_if.man  gpio
);

  // select of the current request
  soc_pkg::sel_t sel;
  // select of the previous transfer
  soc_pkg::sel_t sel_q;
  // transfer this cycle
  logic trn;
  // response cycle, one after a transfer
  logic rsp_q;

  //////////////////////////////
  // address decode
  //////////////////////////////

  always_comb begin
    if (man.adr[`SOC_AW-1:`SOC_MEM_AW] == '0) begin
      // low window
      sel = soc_pkg::SEL_MEM;
    end else if (man.adr[`SOC_AW-1:`SOC_MEM_AW+1] == '0) begin
      // bit SOC_MEM_AW set, nothing above
      sel = soc_pkg::SEL_GPIO;
    end else begin
      sel = soc_pkg::SEL_ERR;
    end
  end

  //////////////////////////////
  // request fan-out
  //////////////////////////////

  // strobe only toward the selected target
  assign mem.vld  = man.vld & (sel == soc_pkg::SEL_MEM);
  assign gpio.vld = man.vld & (sel == soc_pkg::SEL_GPIO);

  // payload unchanged to both
  assign mem.wen  = man.wen;
  assign mem.adr  = man.adr;
  assign mem.ben  = man.ben;
  assign mem.wdt  = man.wdt;
  assign gpio.wen = man.wen;
  assign gpio.adr = man.adr;
  assign gpio.ben = man.ben;
  assign gpio.wdt = man.wdt;

  // ready from the addressed target, unmapped accepts at once
  always_comb begin
    case (sel)
      soc_pkg::SEL_MEM:  man.rdy = mem.rdy;
      soc_pkg::SEL_GPIO: man.rdy = gpio.rdy;
      default:           man.rdy = 1'b1;
    endcase
  end

  assign trn = man.vld & man.rdy;

  // remember where the last transfer went
  always_ff @(posedge bus) begin
    if (rst) begin
      sel_q <= soc_pkg::SEL_MEM;
      rsp_q <= 1'b0;
    end else begin
      rsp_q <= trn;
      if (trn) begin
        sel_q <= sel;
      end
    end
  end

  //////////////////////////////
  // response mux
  //////////////////////////////

  always_comb begin
    case (sel_q)
      soc_pkg::SEL_MEM: begin
        man.rdt = mem.rdt;
        man.err = rsp_q & mem.err;
      end
      soc_pkg::SEL_GPIO: begin
        man.rdt = gpio.rdt;
        man.err = rsp_q & gpio.err;
      end
      default: begin
        // unmapped, zero data with error
        man.rdt = '0;
        man.err = rsp_q;
      end
    endcase
  end

endmodule : tcb_dec

// ==== soc_gpio.sv ====
// GPIO register block
// output register, synchronized input register, registered read-back

`include "soc_config.svh"

module soc_gpio (
  input  logic          bus,
  input  logic          rst,
  tcb_if.sub            tcb,
  input  soc_pkg::gpio_t gpio_in,
  output soc_pkg::gpio_t gpio_out
);

  localparam int unsigned LSB = $clog2(`SOC_BW);

  // word offset inside the GPIO window
  logic [`SOC_MEM_AW-LSB-1:0] ofs;
  // pin synchronizer stages
  soc_pkg::gpio_t sync_0;
  soc_pkg::gpio_t sync_1;
  // output register with the write merged in
  soc_pkg::dat_t out_nxt;

  assign ofs = tcb.adr[`SOC_MEM_AW-1:LSB];

  //////////////////////////////
  // output register
  //////////////////////////////

  // byte merge on the zero-extended register
  always_comb begin
    out_nxt = soc_pkg::dat_t'(gpio_out);
    for (int unsigned b = 0; b < `SOC_BW; b++) begin
      if (tcb.ben[b]) begin
        out_nxt[8*b+:8] = tcb.wdt[8*b+:8];
      end
    end
  end

  // writes only at offset 0, offset 1 is read-only
  always_ff @(posedge bus) begin
    if (rst) begin
      gpio_out <= '0;
    end else if (tcb.vld && tcb.wen && (ofs == 0)) begin
      gpio_out <= out_nxt[`SOC_GPIO_W-1:0];
    end
  end

  //////////////////////////////
  // input synchronizer
  //////////////////////////////

  // two flops, pins are asynchronous
  always_ff @(posedge bus) begin
    sync_0 <= gpio_in;
    sync_1 <= sync_0;
  end

  // read mux, registered like the memory
  always_ff @(posedge bus) begin
    if (tcb.vld && !tcb.wen) begin
      case (ofs)
        0:       tcb.rdt <= soc_pkg::dat_t'(gpio_out);
        1:       tcb.rdt <= soc_pkg::dat_t'(sync_1);
        default: tcb.rdt <= '0;
      endcase
    end
  end

  assign tcb.err = 1'b0;
  assign tcb.rdy = 1'b1;

endmodule : soc_gpio

// ==== soc_top.sv ====
// SoC bus segment top level
// one bus manager port, decoder, memory and GPIO block

module soc_top (
  // clock and reset
  input  logic           bus,
  input  logic           rst,
  // bus request
  input  logic           vld,
  input  logic           wen,
  input  soc_pkg::adr_t  adr,
  input  soc_pkg::ben_t  ben,
  input  soc_pkg::dat_t  wdt,
  // bus response
  output soc_pkg::dat_t  rdt,
  output logic           err,
  output logic           rdy,
  // pins
  input  soc_pkg::gpio_t gpio_in,
  output soc_pkg::gpio_t gpio_out
);

  //////////////////////////////
  // bus instances
  //////////////////////////////

  // from the top level port
  tcb_if tcb_cpu (.clk(bus));
  // decoder to memory
  tcb_if tcb_mem (.clk(bus));
  // decoder to GPIO
  tcb_if tcb_gpio (.clk(bus));

  // request onto the bus
  assign tcb_cpu.vld = vld;
  assign tcb_cpu.wen = wen;
  assign tcb_cpu.adr = adr;
  assign tcb_cpu.ben = ben;
  assign tcb_cpu.wdt = wdt;

  // response back out
  assign rdt = tcb_cpu.rdt;
  assign err = tcb_cpu.err;
  assign rdy = tcb_cpu.rdy;

  //////////////////////////////
  // blocks
  //////////////////////////////

  tcb_dec u_dec (
    .bus  (bus),
    .rst  (rst),
    .man  (tcb_cpu),
    .mem  (tcb_mem),
    .gpio (tcb_gpio)
  );

  soc_mem u_mem (
    .bus (bus),
    .tcb (tcb_mem)
  );

  soc_gpio u_gpio (
    .bus      (bus),
    .rst      (rst),
    .tcb      (tcb_gpio),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

endmodule : soc_top

// ==== soc_assert.sv ====
// bus protocol checks on the SoC top level
// bound to soc_top

module soc_assert (
  input logic           bus,
  input logic           rst,
  input logic           vld,
  input logic           err,
  input logic           rdy,
  input soc_pkg::gpio_t gpio_out
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // protocol
  //////////////////////////////

  // no wait states anywhere in the segment
  rdy_high: assert property (@(posedge bus) rdy)
    else $error("rdy went low although no target stalls");

  // error only in the response cycle of a transfer
  err_after_vld: assert property (@(posedge bus) disable iff (rst) err |-> $past(vld))
    else $error("err high without a transfer in the previous cycle");

  // output register held clear while in reset
  gpio_reset: assert property (@(posedge bus) rst && $past(rst) |-> gpio_out == '0)
    else $error("gpio_out not zero during reset");

endmodule : soc_assert

bind soc_top soc_assert assert_i (
  .bus      (bus),
  .rst      (rst),
  .vld      (vld),
  .err      (err),
  .rdy      (rdy),
  .gpio_out (gpio_out)
);

// ==== tb_soc.sv ====
// SoC bus segment testbench
// replays the transaction trace and checks responses one cycle after each request

module tb_soc;

  timeunit 1ns;
  timeprecision 100ps;

  // DUT ports
  logic           bus;
  logic           rst;
  logic           vld;
  logic           wen;
  soc_pkg::adr_t  adr;
  soc_pkg::ben_t  ben;
  soc_pkg::dat_t  wdt;
  soc_pkg::dat_t  rdt;
  logic           err;
  logic           rdy;
  soc_pkg::gpio_t gpio_in;
  soc_pkg::gpio_t gpio_out;

  // trace columns with one entry per bus cycle
  string          t_name[$];
  logic           t_vld[$];
  logic           t_wen[$];
  soc_pkg::adr_t  t_adr[$];
  soc_pkg::ben_t  t_ben[$];
  soc_pkg::dat_t  t_wdt[$];
  soc_pkg::gpio_t t_gpi[$];
  soc_pkg::dat_t  t_rdt[$];
  logic           t_err[$];
  soc_pkg::gpio_t t_gpo[$];

  int errors;
  int checks;
  logic loaded;

  soc_top dut_i (
    .bus      (bus),
    .rst      (rst),
    .vld      (vld),
    .wen      (wen),
    .adr      (adr),
    .ben      (ben),
    .wdt      (wdt),
    .rdt      (rdt),
    .err      (err),
    .rdy      (rdy),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  // 4 ns bus clock
  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  //////////////////////////////
  // trace handling
  //////////////////////////////

  // fills the queues and skips comment and blank lines
  task automatic load_trace(output logic ok);
    int fd;
    int n;
    string line;
    string nm;
    logic v;
    logic w;
    soc_pkg::adr_t a;
    soc_pkg::ben_t b;
    soc_pkg::dat_t d;
    soc_pkg::gpio_t g;
    soc_pkg::dat_t r;
    logic e;
    soc_pkg::gpio_t o;
    ok = 1'b0;
    fd = $fopen("soc_trace.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", nm, v, w, a, b, d, g, r, e, o);
          if (n == 10) begin
            t_name.push_back(nm);
            t_vld.push_back(v);
            t_wen.push_back(w);
            t_adr.push_back(a);
            t_ben.push_back(b);
            t_wdt.push_back(d);
            t_gpi.push_back(g);
            t_rdt.push_back(r);
            t_err.push_back(e);
            t_gpo.push_back(o);
          end
        end
      end
      $fclose(fd);
      ok = (t_name.size() > 0);
    end
  endtask

  // one line onto the pins right at the rising edge
  task automatic apply_line(input int i);
    vld     <= t_vld[i];
    wen     <= t_wen[i];
    adr     <= t_adr[i];
    ben     <= t_ben[i];
    wdt     <= t_wdt[i];
    gpio_in <= t_gpi[i];
  endtask

  // response of line i sampled mid cycle after its accepting edge
  task automatic check_response(input int i);
    if (t_vld[i]) begin
      checks++;
      assert (err === t_err[i]) else begin
        errors++;
        $display("mismatch %0s err expected %0b actual %0b", t_name[i], t_err[i], err);
      end
      // read data or the zero data of an error response
      if (!t_wen[i] || t_err[i]) begin
        checks++;
        assert (rdt === t_rdt[i]) else begin
          errors++;
          $display("mismatch %0s rdt expected %h actual %h", t_name[i], t_rdt[i], rdt);
        end
      end
    end
    // no wait states in the segment
    checks++;
    assert (rdy === 1'b1) else begin
      errors++;
      $display("mismatch %0s rdy expected 1 actual %0b", t_name[i], rdy);
    end
    checks++;
    assert (gpio_out === t_gpo[i]) else begin
      errors++;
      $display("mismatch %0s gpio_out expected %h actual %h", t_name[i], t_gpo[i], gpio_out);
    end
  endtask

  // reset, replay, closing report
  task automatic run_trace();
    repeat (8) @(posedge bus);
    rst <= 1'b0;
    for (int i = 0; i < t_name.size(); i++) begin
      @(posedge bus);
      apply_line(i);
      @(negedge bus);
      // previous line was accepted at this cycle's edge
      if (i > 0) begin
        check_response(i - 1);
      end
    end
    @(posedge bus);
    vld <= 1'b0;
    @(negedge bus);
    check_response(t_name.size() - 1);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  //////////////////////////////
  // main
  //////////////////////////////

  initial begin
    logic ok;
    rst     = 1'b1;
    vld     = 1'b0;
    wen     = 1'b0;
    adr     = '0;
    ben     = '0;
    wdt     = '0;
    gpio_in = '0;
    errors  = 0;
    checks  = 0;
    loaded  = 1'b0;
    load_trace(ok);
    if (!ok) begin
      $display("could not read any line from soc_trace.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      loaded = 1'b1;
      run_trace();
    end
  end

  // trace length plus reset plus margin in clock periods
  initial begin
    wait (loaded);
    #((t_name.size() + 8 + 16) * 4);
    $display("timeout, the trace did not complete in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_soc

// ==== filelist.f ====
+incdir+.
soc_pkg.sv
tcb_if.sv
soc_mem.sv
tcb_dec.sv
soc_gpio.sv
soc_top.sv
soc_assert.sv
tb_soc.sv

// ==== Makefile ====
# Verilator build for the SoC bus segment testbench

TOP = tb_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f filelist.f --top-module $(TOP) -o V$(TOP)

# exit status follows the search for the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== soc_trace.txt ====
# name vld wen adr ben wdt gpio_in exp_rdt exp_err exp_gpio_out
# hex fields, one bus cycle per line, responses checked one cycle later
wr_lo      1 1 0000 f 11223344 00 00000000 0 00
wr_hi      1 1 0ffc f a5a55a5a 00 00000000 0 00
wr_mid     1 1 0400 f deadbeef 00 00000000 0 00
rd_lo      1 0 0000 f 00000000 00 11223344 0 00
rd_hi      1 0 0ffc f 00000000 00 a5a55a5a 0 00
rd_mid     1 0 0400 f 00000000 00 deadbeef 0 00
be_lane0   1 1 0400 1 000000aa 00 00000000 0 00
be_lane3   1 1 0400 8 55000000 00 00000000 0 00
rd_be      1 0 0400 f 00000000 00 55adbeaa 0 00
be_mid     1 1 0000 6 00cafe00 00 00000000 0 00
rd_be_mid  1 0 0000 0 00000000 00 11cafe44 0 00
gpo_wr     1 1 1000 f 000000c3 00 00000000 0 c3
gpo_rd     1 0 1000 f 00000000 00 000000c3 0 c3
gpo_lane1  1 1 1000 2 0000ff00 00 00000000 0 c3
gpi_set    0 0 0000 0 00000000 5a 00000000 0 c3
idle_a     0 0 0000 0 00000000 5a 00000000 0 c3
gpi_rd     1 0 1004 f 00000000 5a 0000005a 0 c3
gpi_wr     1 1 1004 f 000000ff 5a 00000000 0 c3
gpi_chg    0 0 0000 0 00000000 a5 00000000 0 c3
idle_b     0 0 0000 0 00000000 a5 00000000 0 c3
gpi_rd2    1 0 1004 f 00000000 a5 000000a5 0 c3
err_rd     1 0 2000 f 00000000 a5 00000000 1 c3
err_wr     1 1 8000 f 12345678 a5 00000000 1 c3
err_gpo    1 1 3000 f 000000ff a5 00000000 1 c3
chk_mem    1 0 0000 f 00000000 a5 11cafe44 0 c3
chk_gpo    1 0 1000 f 00000000 a5 000000c3 0 c3
chk_hi     1 0 0ffc f 00000000 a5 a5a55a5a 0 c3
